// ==== common/ig_pkg.sv ====
package ig_pkg;

    // ------------------------------------------------------------
    // image geometry
    // ------------------------------------------------------------

    // edge length as a power of two, 8x8 in simulation
    localparam int img_dim_log2 = 3;
    localparam int img_dim = 1 << img_dim_log2;
    localparam int img_pixels = img_dim * img_dim;

    // ------------------------------------------------------------
    // data widths
    // ------------------------------------------------------------

    typedef logic [15:0] addr_t;
    typedef logic [7:0] pixel_t;

    // pixel differences span -255 .. +255
    typedef logic signed [9:0] diff_t;

    // Gx in [19:10], Gy in [9:0]
    typedef logic [19:0] grad_t;

    // ------------------------------------------------------------
    // pipeline payloads
    // ------------------------------------------------------------

    // one pixel from the scanner, flush marks padding past the image
    typedef struct packed {
        logic   valid;
        pixel_t pixel;
        logic   flush;
    } pix_step_t;

    // neighbourhood of the current pixel
    typedef struct packed {
        logic   valid;
        pixel_t centre;
        pixel_t right;
        pixel_t below;
    } tap_t;

    // result of one difference unit
    typedef struct packed {
        logic  valid;
        diff_t value;
    } diff_res_t;

endpackage

// ==== rtl/scan_ctrl.sv ====
module scan_ctrl (
    input  logic              clk,
    input  logic              reset,
    output logic              img_rd,
    output ig_pkg::addr_t     img_addr,
    input  ig_pkg::pixel_t    img_di,
    output ig_pkg::pix_step_t step
);
    import ig_pkg::*;

    typedef enum logic [1:0] {
        scan_read,
        scan_flush,
        scan_idle
    } scan_state_t;

    scan_state_t state;
    logic [img_dim_log2-1:0] flush_cnt;
    logic rd_q;
    logic flush_q;

    // ------------------------------------------------------------
    // address scan, then one row of flush steps
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= scan_read;
            img_rd <= 1'b0;
            img_addr <= '0;
            flush_cnt <= '0;
            rd_q <= 1'b0;
            flush_q <= 1'b0;
        end else begin
            // memory answers one cycle after the strobe
            rd_q <= img_rd;
            flush_q <= 1'b0;
            case (state)
                scan_read: begin
                    img_rd <= 1'b1;
                    if (img_rd) begin
                        if (img_addr == addr_t'(img_pixels - 1)) begin
                            img_rd <= 1'b0;
                            state <= scan_flush;
                        end else begin
                            img_addr <= img_addr + 1'b1;
                        end
                    end
                end
                scan_flush: begin
                    flush_q <= 1'b1;
                    flush_cnt <= flush_cnt + 1'b1;
                    // all ones is the last of img_dim steps
                    if (flush_cnt == '1) begin
                        state <= scan_idle;
                    end
                end
                default: begin
                    state <= scan_idle;
                end
            endcase
        end
    end

    // pixel is don't-care on flush steps
    assign step = '{valid: rd_q | flush_q, pixel: img_di, flush: flush_q};

    a_addr_range: assert property (@(posedge clk) disable iff (reset)
        img_rd |-> (int'(img_addr) < img_pixels))
        else $error("image read address out of range");

endmodule

// ==== window/pixel_window.sv ====
module pixel_window (
    input  logic              clk,
    input  logic              reset,
    input  ig_pkg::pix_step_t step,
    output ig_pkg::tap_t      taps
);
    import ig_pkg::*;

    // incoming pixel, padding forced to zero
    pixel_t below;

    // line_q[n] holds the pixel that entered n steps ago;
    // with the incoming pixel the window is img_dim+1 deep
    pixel_t line_q [1:img_dim];

    // counts every step, taps only valid inside the image
    logic [2*img_dim_log2:0] step_cnt;
    logic in_range;

    assign below = step.flush ? '0 : step.pixel;

    // ------------------------------------------------------------
    // row delay line
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (step.valid) begin
            line_q[1] <= below;
            for (int i = 2; i <= img_dim; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    // ------------------------------------------------------------
    // fill and tap counting
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            step_cnt <= '0;
        end else if (step.valid) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // first img_dim steps only fill the line
    assign in_range = (step_cnt >= img_dim) && (step_cnt < img_dim + img_pixels);

    // below arrives this cycle, centre one row back
    assign taps = '{
        valid:  step.valid && in_range,
        centre: line_q[img_dim],
        right:  line_q[img_dim-1],
        below:  below
    };

    // scanner sends exactly one image plus one flush row
    a_step_count: assert property (@(posedge clk) disable iff (reset)
        step.valid |-> (int'(step_cnt) < img_dim + img_pixels))
        else $error("more steps than image plus flush row");

endmodule

// ==== gradient/gx_unit.sv ====
module gx_unit (
    input  logic              clk,
    input  logic              reset,
    input  ig_pkg::tap_t      taps,
    output ig_pkg::diff_res_t gx
);
    import ig_pkg::*;

    // one spare bit so the range check means something
    logic [img_dim_log2:0] col;
    logic valid_q;
    diff_t value_q;
    logic last_col;

    assign last_col = (col == img_dim - 1);

    // ------------------------------------------------------------
    // column tracking
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= taps.valid;
            if (taps.valid) begin
                col <= last_col ? '0 : col + 1'b1;
            end
        end
    end

    // right minus centre, no neighbour in the last column
    always_ff @(posedge clk) begin
        if (taps.valid) begin
            if (last_col) begin
                value_q <= '0;
            end else begin
                value_q <= diff_t'({2'b00, taps.right}) - diff_t'({2'b00, taps.centre});
            end
        end
    end

    assign gx = '{valid: valid_q, value: value_q};

    a_col_range: assert property (@(posedge clk) disable iff (reset)
        int'(col) < img_dim)
        else $error("gx column counter out of range");

endmodule

// ==== gradient/gy_unit.sv ====
module gy_unit (
    input  logic              clk,
    input  logic              reset,
    input  ig_pkg::tap_t      taps,
    output ig_pkg::diff_res_t gy
);
    import ig_pkg::*;

    logic [img_dim_log2-1:0] col;
    logic [img_dim_log2-1:0] row;
    logic valid_q;
    diff_t value_q;
    logic last_col;
    logic last_row;

    assign last_col = (col == img_dim - 1);
    assign last_row = (row == img_dim - 1);

    // ------------------------------------------------------------
    // tap position
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
            row <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= taps.valid;
            if (taps.valid) begin
                col <= last_col ? '0 : col + 1'b1;
                if (last_col) begin
                    row <= last_row ? '0 : row + 1'b1;
                end
            end
        end
    end

    // below minus centre; in the last row below is flush padding
    always_ff @(posedge clk) begin
        if (taps.valid) begin
            if (last_row) begin
                value_q <= '0;
            end else begin
                value_q <= diff_t'({2'b00, taps.below}) - diff_t'({2'b00, taps.centre});
            end
        end
    end

    assign gy = '{valid: valid_q, value: value_q};

endmodule

// ==== gradient/grad_pack.sv ====
module grad_pack (
    input  logic              clk,
    input  logic              reset,
    input  ig_pkg::diff_res_t gx,
    input  ig_pkg::diff_res_t gy,
    output logic              grad_wr,
    output ig_pkg::addr_t     grad_addr,
    output ig_pkg::grad_t     grad_do,
    output logic              done
);
    import ig_pkg::*;

    addr_t next_addr;
    logic both_valid;

    assign both_valid = gx.valid & gy.valid;

    // ------------------------------------------------------------
    // write strobe, address and completion
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            grad_addr <= '0;
            next_addr <= '0;
            done <= 1'b0;
        end else begin
            grad_wr <= both_valid;
            if (both_valid) begin
                grad_addr <= next_addr;
                next_addr <= next_addr + 1'b1;
            end
            // last word goes out this cycle
            if (grad_wr && grad_addr == addr_t'(img_pixels - 1)) begin
                done <= 1'b1;
            end
        end
    end

    // Gx upper, Gy lower
    always_ff @(posedge clk) begin
        if (both_valid) begin
            grad_do <= {gx.value, gy.value};
        end
    end

    // both units are fed the same taps with equal latency
    a_valid_match: assert property (@(posedge clk) disable iff (reset)
        gx.valid == gy.valid)
        else $error("gx and gy results out of step");

endmodule

// ==== rtl/ig_top.sv ====
module ig_top (
    input  logic           clk,
    input  logic           reset,
    output logic           img_rd,
    output ig_pkg::addr_t  img_addr,
    input  ig_pkg::pixel_t img_di,
    output logic           grad_wr,
    output ig_pkg::addr_t  grad_addr,
    output ig_pkg::grad_t  grad_do,
    output logic           done
);
    import ig_pkg::*;

    pix_step_t step;
    tap_t taps;
    diff_res_t gx;
    diff_res_t gy;

    // ------------------------------------------------------------
    // image read and row window
    // ------------------------------------------------------------
    scan_ctrl scan0 (
        .clk      (clk),
        .reset    (reset),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di),
        .step     (step)
    );

    pixel_window window0 (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .taps  (taps)
    );

    // ------------------------------------------------------------
    // differences, side by side
    // ------------------------------------------------------------
    gx_unit gx0 (
        .clk   (clk),
        .reset (reset),
        .taps  (taps),
        .gx    (gx)
    );

    gy_unit gy0 (
        .clk   (clk),
        .reset (reset),
        .taps  (taps),
        .gy    (gy)
    );

    // gradient memory write
    grad_pack pack0 (
        .clk       (clk),
        .reset     (reset),
        .gx        (gx),
        .gy        (gy),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

// ==== tb/tb_ig.sv ====
module tb_ig;
    timeunit 1ns;
    timeprecision 100ps;

    import ig_pkg::*;

    // three clock periods per pixel plus margin
    localparam int watchdog_cycles = img_pixels * 3 + 50;

    logic clk = 1'b0;
    logic reset;
    logic img_rd;
    addr_t img_addr;
    pixel_t img_di;
    logic grad_wr;
    addr_t grad_addr;
    grad_t grad_do;
    logic done;

    // pixels first, expected words after them
    grad_t trace_words [0:2*img_pixels-1];
    pixel_t img_mem [0:img_pixels-1];
    grad_t expected [0:img_pixels-1];
    int write_hits [0:img_pixels-1];

    // read strobe of the previous cycle
    logic pend_rd;
    addr_t pend_addr;

    int cycle;
    int rd_count;
    int wr_count;
    int first_rd_cycle;
    logic done_seen;
    logic last_wr_prev;

    ig_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // forward differences straight from the pixel array
    function automatic grad_t rule_word(input int idx);
        int r;
        int c;
        int gx;
        int gy;
        r = idx / img_dim;
        c = idx % img_dim;
        gx = 0;
        gy = 0;
        if (c != img_dim - 1) begin
            gx = int'(img_mem[idx + 1]) - int'(img_mem[idx]);
        end
        if (r != img_dim - 1) begin
            gy = int'(img_mem[idx + img_dim]) - int'(img_mem[idx]);
        end
        return {diff_t'(gx), diff_t'(gy)};
    endfunction

    task automatic load_trace();
        $readmemh("tb/ig_trace.txt", trace_words);
        for (int i = 0; i < img_pixels; i++) begin
            assert (!$isunknown(trace_words[i]) && trace_words[i] < 20'd256)
                else report_failure($sformatf("trace pixel %0d is missing or too wide", i));
            assert (!$isunknown(trace_words[img_pixels + i]))
                else report_failure($sformatf("trace gradient word %0d is missing", i));
            img_mem[i] = pixel_t'(trace_words[i]);
            expected[i] = trace_words[img_pixels + i];
            write_hits[i] = 0;
        end
        // trace words have to obey the difference rule
        for (int i = 0; i < img_pixels; i++) begin
            assert (expected[i] == rule_word(i))
                else report_failure($sformatf("trace word %0d does not match its pixels", i));
        end
    endtask

    // ------------------------------------------------------------
    // image memory, data one cycle after the strobe
    // ------------------------------------------------------------
    always @(negedge clk) begin
        pend_rd = img_rd;
        pend_addr = img_addr;
    end

    always @(posedge clk) begin
        #1;
        if (pend_rd === 1'b1) begin
            img_di = img_mem[pend_addr];
        end
    end

    // ------------------------------------------------------------
    // bus monitors, sampled mid cycle
    // ------------------------------------------------------------
    task automatic check_reads();
        if (img_rd) begin
            assert (rd_count < img_pixels)
                else report_failure("image read strobe high after the last pixel was read");
            assert (int'(img_addr) == rd_count)
                else report_mismatch($sformatf("img_addr %0d, expected %0d", img_addr, rd_count));
            if (rd_count == 0) begin
                first_rd_cycle = cycle;
            end
            rd_count++;
        end else begin
            assert (rd_count == 0 || rd_count == img_pixels)
                else report_failure("image read strobe dropped before the last pixel");
        end
    endtask

    task automatic check_writes();
        int idx;
        int r;
        int c;
        if (grad_wr) begin
            idx = int'(grad_addr);
            assert (!done_seen) else report_failure("gradient write after done");
            assert (idx < img_pixels)
                else report_mismatch($sformatf("grad_addr %0d out of range", idx));
            write_hits[idx]++;
            assert (write_hits[idx] == 1)
                else report_mismatch($sformatf("address %0d written twice", idx));
            assert (idx == wr_count)
                else report_mismatch($sformatf("grad_addr %0d, expected %0d", idx, wr_count));
            if (wr_count == 0) begin
                assert (cycle - first_rd_cycle == img_dim + 3)
                    else report_mismatch($sformatf("latency %0d cycles, expected %0d",
                        cycle - first_rd_cycle, img_dim + 3));
            end
            r = idx / img_dim;
            c = idx % img_dim;
            assert (c != img_dim - 1 || grad_do[19:10] == '0)
                else report_mismatch($sformatf("Gx not zero in last column, address %0d", idx));
            assert (r != img_dim - 1 || grad_do[9:0] == '0)
                else report_mismatch($sformatf("Gy not zero in last row, address %0d", idx));
            assert (grad_do == expected[idx])
                else report_mismatch($sformatf("address %0d word %05h, expected %05h",
                    idx, grad_do, expected[idx]));
            wr_count++;
        end else begin
            assert (wr_count == 0 || wr_count == img_pixels)
                else report_failure("gradient writes not on consecutive cycles");
        end
    endtask

    task automatic check_done();
        if (last_wr_prev) begin
            assert (done) else report_failure("done did not rise after the last write");
        end
        if (done) begin
            assert (wr_count == img_pixels)
                else report_failure("done high before all words were written");
            done_seen = 1'b1;
        end else begin
            assert (!done_seen) else report_failure("done fell again before reset");
        end
        last_wr_prev = grad_wr && (wr_count == img_pixels);
    endtask

    always @(negedge clk) begin
        if (reset === 1'b0) begin
            cycle++;
            check_reads();
            check_writes();
            check_done();
        end
    end

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        reset = 1'b1;
        img_di = '0;
        pend_rd = 1'b0;
        pend_addr = '0;
        cycle = 0;
        rd_count = 0;
        wr_count = 0;
        first_rd_cycle = 0;
        done_seen = 1'b0;
        last_wr_prev = 1'b0;
        load_trace();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (img_rd === 1'b0 && grad_wr === 1'b0 && done === 1'b0)
            else report_failure("img_rd, grad_wr or done not low after reset");
        wait (done_seen);
        // done holds and no write follows
        repeat (2 * img_dim) @(negedge clk);
        #1;
        assert (rd_count == img_pixels)
            else report_failure($sformatf("%0d image reads instead of %0d", rd_count, img_pixels));
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: done not seen within %0d clock periods", watchdog_cycles);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== tb/ig_trace.txt ====
// image: 8 rows of 8 pixels, one hex byte per column, raster order
// then expected gradient words: 8 rows of 8, Gx in [19:10], Gy in [9:0]
00 FF 00 10 20 30 40 50
FF 00 FF 11 22 33 44 55
10 10 10 10 10 10 10 10
01 02 04 08 10 20 40 80
80 40 20 10 08 04 02 01
00 00 00 00 FF FF FF FF
05 0A 0F 14 19 1E 23 28
33 66 99 CC FF 00 7F 80
// expected gradient words
3FCFF C0701 040FF 04001 04002 04003 04004 00005
C0711 3FC10 C4B11 047FF 047EE 047DD 047CC 003BB
003F1 003F2 003F4 003F8 00000 00010 00030 00070
0047F 0083E 0101C 02008 043F8 083E4 103C2 00381
F0380 F83C0 FC3E0 FE3F0 FF0F7 FF8FB FFCFD 000FE
00005 0000A 0000F 3FC14 0031A 0031F 00324 00329
0142E 0145C 0148A 014B8 014E6 017E2 0145C 00058
0CC00 0CC00 0CC00 0CC00 C0400 1FC00 00400 00000

// ==== verilog.f ====
common/ig_pkg.sv
rtl/scan_ctrl.sv
window/pixel_window.sv
gradient/gx_unit.sv
gradient/gy_unit.sv
gradient/grad_pack.sv
rtl/ig_top.sv
tb/tb_ig.sv

// ==== Makefile ====
TOP = tb_ig
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module ig_top -f verilog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f verilog.f -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
